//--- logic/isa_pkg.sv
package isa_pkg;

	// Primary opcodes of the branch subset, bits 31:26 of the word
	localparam logic [5:0] OP_J    = 6'h02;
	localparam logic [5:0] OP_JAL  = 6'h03;
	localparam logic [5:0] OP_BEQ  = 6'h04;
	localparam logic [5:0] OP_BNE  = 6'h05;
	localparam logic [5:0] OP_BLEZ = 6'h06;
	localparam logic [5:0] OP_BGTZ = 6'h07;

	// I-format, used by the conditional branches
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;	// Word offset from pc+4
	} i_fmt_t;

	// J-format, used by J and JAL
	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] index;	// Word index inside the current 256 MB region
	} j_fmt_t;

	// One instruction word, seen either way
	typedef union packed {
		i_fmt_t i;
		j_fmt_t j;
	} instr_u;

endpackage

//--- logic/bp_pkg.sv
package bp_pkg;

	// Program counter or branch target
	typedef logic [31:0] pc_t;

	// Statistics counter, wraps at 2**16
	typedef logic [15:0] stat_t;

	// Branch class found by decode
	typedef enum logic [2:0] {
		BK_NONE = 3'd0,
		BK_BEQ  = 3'd1,
		BK_BNE  = 3'd2,
		BK_BLEZ = 3'd3,
		BK_BGTZ = 3'd4,
		BK_JUMP = 3'd5	// J and JAL alike
	} branch_kind_e;

endpackage

//--- logic/pred_ram.sv
`timescale 1ns/1ps

module pred_ram #(
	parameter int TABLE_LOG2 = 12
) (
	input  logic                  clk,
	input  logic                  wr_en,
	input  logic [TABLE_LOG2-1:0] wr_addr,
	input  logic                  wr_data,
	input  logic                  rd_en,
	input  logic [TABLE_LOG2-1:0] rd_addr,
	output logic                  rd_data
);

	localparam int DEPTH = 2 ** TABLE_LOG2;

	logic entries [DEPTH];

	// Power-up contents of the block RAM, all not taken
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			entries[i] = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			entries[wr_addr] <= wr_data;
		end
		// Same-address read in the write edge sees the old bit
		if (rd_en) begin
			rd_data <= entries[rd_addr];
		end
	end

endmodule

//--- logic/branch_predictor.sv
`timescale 1ns/1ps

// One-bit bimodal predictor: every entry holds the last outcome seen at its index
module branch_predictor #(
	parameter int TABLE_LOG2 = 12
) (
	input  logic                  clk,
	input  logic                  pred_req,
	input  logic [TABLE_LOG2-1:0] pred_index,
	input  logic                  train_en,
	input  logic [TABLE_LOG2-1:0] train_index,
	input  logic                  train_taken,
	output logic                  prediction
);

	logic                  wr_en;
	logic [TABLE_LOG2-1:0] wr_addr;
	logic                  wr_data;

	// Training stores the resolved direction as the new state
	always_comb begin
		wr_en   = train_en;
		wr_addr = train_index;
		wr_data = train_taken;	// 1 taken, 0 not taken
	end

	// Read port is enabled only on requests, so the answer holds between them
	pred_ram #(
		.TABLE_LOG2(TABLE_LOG2)
	) pred_table (
		.clk    (clk),
		.wr_en  (wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_en  (pred_req),
		.rd_addr(pred_index),
		.rd_data(prediction)
	);

endmodule

//--- logic/branch_decode.sv
`timescale 1ns/1ps

module branch_decode import isa_pkg::*, bp_pkg::*; #(
	parameter int TABLE_LOG2 = 12
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  pc_t                   in_pc,
	input  instr_u                in_instr,
	input  logic [31:0]           rs_val,
	input  logic [31:0]           rt_val,
	output logic                  pred_req,
	output logic [TABLE_LOG2-1:0] pred_index,
	output logic                  dec_valid,
	output branch_kind_e          dec_kind,
	output pc_t                   dec_pc,
	output pc_t                   dec_target,
	output logic [31:0]           dec_rs,
	output logic [31:0]           dec_rt
);

	branch_kind_e kind;
	pc_t          pc_plus4;
	pc_t          br_target;
	pc_t          j_target;
	logic         is_cond;

	always_comb begin
		case (in_instr.i.opcode)
			OP_BEQ:        kind = BK_BEQ;
			OP_BNE:        kind = BK_BNE;
			OP_BLEZ:       kind = BK_BLEZ;
			OP_BGTZ:       kind = BK_BGTZ;
			OP_J, OP_JAL:  kind = BK_JUMP;
			default:       kind = BK_NONE;
		endcase
	end

	assign is_cond = (kind != BK_NONE) && (kind != BK_JUMP);

	// Target arithmetic through the two views of the word
	assign pc_plus4  = in_pc + 32'd4;
	assign br_target = pc_plus4 + {{14{in_instr.i.imm[15]}}, in_instr.i.imm, 2'b00};
	assign j_target  = {pc_plus4[31:28], in_instr.j.index, 2'b00};

	// Table read starts this cycle, answer lines up with the dec_* registers
	assign pred_req   = in_valid && is_cond;
	assign pred_index = in_pc[TABLE_LOG2+1:2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= in_valid && (kind != BK_NONE);	// Non-branches drop out here
		end
	end

	always_ff @(posedge clk) begin
		dec_kind   <= kind;
		dec_pc     <= in_pc;
		dec_target <= (kind == BK_JUMP) ? j_target : br_target;
		dec_rs     <= rs_val;
		dec_rt     <= rt_val;
	end

endmodule

//--- logic/branch_execute.sv
`timescale 1ns/1ps

module branch_execute import bp_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         dec_valid,
	input  branch_kind_e dec_kind,
	input  pc_t          dec_pc,
	input  pc_t          dec_target,
	input  logic [31:0]  dec_rs,
	input  logic [31:0]  dec_rt,
	input  logic         prediction,
	output logic         ex_valid,
	output branch_kind_e ex_kind,
	output pc_t          ex_pc,
	output pc_t          ex_target,
	output logic         ex_taken,
	output logic         ex_predicted
);

	logic cond;
	logic rs_eq_rt;
	logic rs_neg;
	logic rs_zero;

	assign rs_eq_rt = (dec_rs == dec_rt);
	assign rs_neg   = dec_rs[31];	// rs taken as signed
	assign rs_zero  = (dec_rs == 32'd0);

	// Actual direction per kind
	always_comb begin
		case (dec_kind)
			BK_BEQ:  cond = rs_eq_rt;
			BK_BNE:  cond = !rs_eq_rt;
			BK_BLEZ: cond = rs_neg || rs_zero;
			BK_BGTZ: cond = !rs_neg && !rs_zero;
			BK_JUMP: cond = 1'b1;
			default: cond = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= dec_valid;
		end
	end

	always_ff @(posedge clk) begin
		ex_kind      <= dec_kind;
		ex_pc        <= dec_pc;
		ex_target    <= dec_target;
		ex_taken     <= cond;
		// Jumps never read the table and are always called taken
		ex_predicted <= (dec_kind == BK_JUMP) ? 1'b1 : prediction;
	end

endmodule

//--- logic/branch_result.sv
`timescale 1ns/1ps

module branch_result import bp_pkg::*; #(
	parameter int TABLE_LOG2 = 12
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ex_valid,
	input  branch_kind_e          ex_kind,
	input  pc_t                   ex_pc,
	input  pc_t                   ex_target,
	input  logic                  ex_taken,
	input  logic                  ex_predicted,
	output logic                  out_valid,
	output pc_t                   out_pc,
	output logic                  taken,
	output logic                  predicted,
	output logic                  mispredict,
	output pc_t                   redirect_pc,
	output stat_t                 branch_count,
	output stat_t                 mispredict_count,
	output logic                  train_en,
	output logic [TABLE_LOG2-1:0] train_index,
	output logic                  train_taken
);

	logic miss;

	assign miss = ex_valid && (ex_taken != ex_predicted);

	// Table write happens in the edge that registers the result
	assign train_en    = ex_valid && (ex_kind != BK_JUMP) && (ex_kind != BK_NONE);
	assign train_index = ex_pc[TABLE_LOG2+1:2];
	assign train_taken = ex_taken;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid        <= 1'b0;
			mispredict       <= 1'b0;
			branch_count     <= '0;
			mispredict_count <= '0;
		end else begin
			out_valid  <= ex_valid;
			mispredict <= miss;
			if (ex_valid) begin
				branch_count <= branch_count + 1'b1;	// Wraps
			end
			if (miss) begin
				mispredict_count <= mispredict_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		out_pc      <= ex_pc;
		taken       <= ex_taken;
		predicted   <= ex_predicted;
		redirect_pc <= ex_taken ? ex_target : ex_pc + 32'd4;	// Fall-through when not taken
	end

endmodule

//--- logic/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import isa_pkg::*, bp_pkg::*; #(
	parameter int TABLE_LOG2 = 12
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid,
	input  pc_t         in_pc,
	input  instr_u      in_instr,
	input  logic [31:0] rs_val,
	input  logic [31:0] rt_val,
	output logic        out_valid,
	output pc_t         out_pc,
	output logic        taken,
	output logic        predicted,
	output logic        mispredict,
	output pc_t         redirect_pc,
	output stat_t       branch_count,
	output stat_t       mispredict_count
);

	// Predictor request and training
	logic                  pred_req;
	logic [TABLE_LOG2-1:0] pred_index;
	logic                  prediction;
	logic                  train_en;
	logic [TABLE_LOG2-1:0] train_index;
	logic                  train_taken;

	// Decode to execute
	logic         dec_valid;
	branch_kind_e dec_kind;
	pc_t          dec_pc;
	pc_t          dec_target;
	logic [31:0]  dec_rs;
	logic [31:0]  dec_rt;

	// Execute to result
	logic         ex_valid;
	branch_kind_e ex_kind;
	pc_t          ex_pc;
	pc_t          ex_target;
	logic         ex_taken;
	logic         ex_predicted;

	branch_decode #(
		.TABLE_LOG2(TABLE_LOG2)
	) decode_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_pc     (in_pc),
		.in_instr  (in_instr),
		.rs_val    (rs_val),
		.rt_val    (rt_val),
		.pred_req  (pred_req),
		.pred_index(pred_index),
		.dec_valid (dec_valid),
		.dec_kind  (dec_kind),
		.dec_pc    (dec_pc),
		.dec_target(dec_target),
		.dec_rs    (dec_rs),
		.dec_rt    (dec_rt)
	);

	branch_predictor #(
		.TABLE_LOG2(TABLE_LOG2)
	) predictor_inst (
		.clk        (clk),
		.pred_req   (pred_req),
		.pred_index (pred_index),
		.train_en   (train_en),
		.train_index(train_index),
		.train_taken(train_taken),
		.prediction (prediction)
	);

	branch_execute execute_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.dec_valid   (dec_valid),
		.dec_kind    (dec_kind),
		.dec_pc      (dec_pc),
		.dec_target  (dec_target),
		.dec_rs      (dec_rs),
		.dec_rt      (dec_rt),
		.prediction  (prediction),
		.ex_valid    (ex_valid),
		.ex_kind     (ex_kind),
		.ex_pc       (ex_pc),
		.ex_target   (ex_target),
		.ex_taken    (ex_taken),
		.ex_predicted(ex_predicted)
	);

	branch_result #(
		.TABLE_LOG2(TABLE_LOG2)
	) result_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.ex_valid        (ex_valid),
		.ex_kind         (ex_kind),
		.ex_pc           (ex_pc),
		.ex_target       (ex_target),
		.ex_taken        (ex_taken),
		.ex_predicted    (ex_predicted),
		.out_valid       (out_valid),
		.out_pc          (out_pc),
		.taken           (taken),
		.predicted       (predicted),
		.mispredict      (mispredict),
		.redirect_pc     (redirect_pc),
		.branch_count    (branch_count),
		.mispredict_count(mispredict_count),
		.train_en        (train_en),
		.train_index     (train_index),
		.train_taken     (train_taken)
	);

endmodule

//--- sim/branch_unit_chk.sv
`timescale 1ns/1ps

module branch_unit_chk import bp_pkg::*; (
	input logic  clk,
	input logic  rst_n,
	input logic  out_valid,
	input logic  mispredict,
	input stat_t branch_count
);

	int fail_count = 0;	// Assertion failures so far

	// Reset clears the output strobe by the next edge
	property quiet_after_reset;
		@(posedge clk) !rst_n |=> !out_valid;
	endproperty

	property miss_needs_valid;
		@(posedge clk) disable iff (!rst_n) mispredict |-> out_valid;
	endproperty

	// Counter moves in the same edge that raises out_valid
	property count_steps_by_one;
		@(posedge clk) disable iff (!rst_n)
			out_valid |-> branch_count == $past(branch_count) + 16'd1;
	endproperty

	assert property (quiet_after_reset)
		else begin
			$error("out_valid high in the cycle after reset");
			fail_count++;
		end
	assert property (miss_needs_valid)
		else begin
			$error("mispredict high without out_valid");
			fail_count++;
		end
	assert property (count_steps_by_one)
		else begin
			$error("branch_count did not step by one with out_valid");
			fail_count++;
		end

endmodule

//--- sim/branch_unit_tb.sv
`timescale 1ns/1ps

module branch_unit_tb import isa_pkg::*, bp_pkg::*; ();

	localparam int TABLE_LOG2  = 6;
	localparam int N_INSTR     = 2000;
	localparam int STIM_CYCLES = N_INSTR * 3 + 40;	// At most two idle cycles per instruction
	localparam int WATCHDOG_NS = 2 * STIM_CYCLES * 4 + 200;

	// One expected result, in the order branches were sent in
	typedef struct {
		pc_t                   pc;
		logic [TABLE_LOG2-1:0] idx;
		logic                  cond;	// Conditional, so it trains the table
		logic                  taken;
		logic                  predicted;
		logic                  mispredict;
		pc_t                   redirect;
	} result_t;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        in_valid;
	pc_t         in_pc;
	instr_u      in_instr;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic        out_valid;
	pc_t         out_pc;
	logic        taken;
	logic        predicted;
	logic        mispredict;
	pc_t         redirect_pc;
	stat_t       branch_count;
	stat_t       mispredict_count;
	logic        rst_q = 1'b0;	// rst_n as seen at the last rising edge

	result_t exp_q [$];
	logic    table_m [2 ** TABLE_LOG2];
	pc_t     pc_pool [16];
	stat_t   exp_branches = '0;
	stat_t   exp_misses = '0;
	int      value_errors = 0;
	int      other_errors = 0;
	int      result_count = 0;

	always #2 clk = ~clk;

	branch_unit #(
		.TABLE_LOG2(TABLE_LOG2)
	) branch_unit_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.in_valid        (in_valid),
		.in_pc           (in_pc),
		.in_instr        (in_instr),
		.rs_val          (rs_val),
		.rt_val          (rt_val),
		.out_valid       (out_valid),
		.out_pc          (out_pc),
		.taken           (taken),
		.predicted       (predicted),
		.mispredict      (mispredict),
		.redirect_pc     (redirect_pc),
		.branch_count    (branch_count),
		.mispredict_count(mispredict_count)
	);

	bind branch_unit branch_unit_chk chk_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.out_valid   (out_valid),
		.mispredict  (mispredict),
		.branch_count(branch_count)
	);

	task automatic check_flag(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			$display("FAIL t=%0t %s expected %0b actual %0b", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_pc(input string name, input pc_t act, input pc_t exp);
		if (act !== exp) begin
			$display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input stat_t act, input stat_t exp);
		if (act !== exp) begin
			$display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
			value_errors++;
		end
	endtask

	// Often zero, negative or small, so BLEZ and BGTZ see both sides
	function automatic logic [31:0] pick_operand();
		case ($urandom_range(3, 0))
			0:       return 32'd0;
			1:       return $urandom | 32'h8000_0000;
			2:       return $urandom_range(8, 1);
			default: return $urandom;
		endcase
	endfunction

	function automatic logic [5:0] pick_opcode();
		case ($urandom_range(11, 0))
			0, 1:    return OP_BEQ;
			2, 3:    return OP_BNE;
			4, 5:    return OP_BLEZ;
			6, 7:    return OP_BGTZ;
			8:       return OP_J;
			9:       return OP_JAL;
			10:      return 6'h08;	// ADDI
			default: return 6'h23;	// LW
		endcase
	endfunction

	task automatic drive_idle();
		@(negedge clk);
		in_valid = 1'b0;
		in_instr = $urandom;	// Junk, the DUT must ignore it
	endtask

	task automatic drive_instr();
		logic [31:0] word;
		@(negedge clk);
		word        = $urandom;
		word[31:26] = pick_opcode();
		in_valid    = 1'b1;
		in_pc       = pc_pool[$urandom_range(15, 0)];
		in_instr    = word;
		rs_val      = pick_operand();
		rt_val      = ($urandom_range(1, 0) == 0) ? rs_val : pick_operand();
	endtask

	// Drain, reset, then expect cleared counters and a quiet output
	task automatic reset_mid_run();
		while (exp_q.size() != 0) begin
			drive_idle();
		end
		drive_idle();
		rst_n = 1'b0;
		repeat (4) drive_idle();
		rst_n = 1'b1;
		repeat (3) begin
			drive_idle();
			check_flag("out_valid", out_valid, 1'b0);
			check_count("branch_count", branch_count, 16'd0);
			check_count("mispredict_count", mispredict_count, 16'd0);
		end
	endtask

	// Reference model, predicts from the table as it stands at the sampling edge
	always @(posedge clk) begin : model_sample
		result_t     r;
		pc_t         pc4;
		logic [31:0] offset;
		logic        is_branch;
		rst_q <= rst_n;
		if (rst_n && in_valid) begin
			pc4       = in_pc + 32'd4;
			offset    = {{16{in_instr.i.imm[15]}}, in_instr.i.imm};
			is_branch = 1'b1;
			r.pc      = in_pc;
			r.idx     = in_pc[TABLE_LOG2+1:2];
			r.cond    = 1'b1;
			case (in_instr.i.opcode)
				OP_BEQ:  r.taken = (rs_val == rt_val);
				OP_BNE:  r.taken = (rs_val != rt_val);
				OP_BLEZ: r.taken = ($signed(rs_val) <= 0);
				OP_BGTZ: r.taken = ($signed(rs_val) > 0);
				OP_J, OP_JAL: begin
					r.cond  = 1'b0;
					r.taken = 1'b1;
				end
				default: is_branch = 1'b0;
			endcase
			if (is_branch) begin
				r.predicted  = r.cond ? table_m[r.idx] : 1'b1;
				r.mispredict = (r.predicted != r.taken);
				if (!r.taken)
					r.redirect = pc4;
				else if (r.cond)
					r.redirect = pc4 + (offset << 2);
				else
					r.redirect = {pc4[31:28], in_instr.j.index, 2'b00};
				exp_q.push_back(r);
			end
		end
	end

	// Outputs settle after the rising edge and are compared half a cycle later
	always @(negedge clk) begin : check_outputs
		result_t r;
		if (!rst_q) begin
			exp_branches = '0;
			exp_misses   = '0;
		end else if (out_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("ERROR t=%0t out_valid raised with no branch in flight", $time);
				other_errors++;
			end else begin
				r = exp_q.pop_front();
				result_count++;
				exp_branches++;
				if (r.mispredict) exp_misses++;
				check_pc("out_pc", out_pc, r.pc);
				check_flag("taken", taken, r.taken);
				check_flag("predicted", predicted, r.predicted);
				check_flag("mispredict", mispredict, r.mispredict);
				// Jumps never mispredict, their target only shows here
				if (r.mispredict || !r.cond) check_pc("redirect_pc", redirect_pc, r.redirect);
				if (r.cond) table_m[r.idx] = r.taken;	// Write lands with the result
				check_count("branch_count", branch_count, exp_branches);
				check_count("mispredict_count", mispredict_count, exp_misses);
			end
		end
	end

	initial begin : stimulus
		void'($urandom(32'ha84d));
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_pc    = '0;
		in_instr = '0;
		rs_val   = '0;
		rt_val   = '0;
		for (int i = 0; i < 2 ** TABLE_LOG2; i++) table_m[i] = 1'b0;
		// 16 PCs share 6 table entries so branches alias
		for (int i = 0; i < 16; i++) begin
			pc_pool[i] = ($urandom & 32'hffff_ff00) | ((i % 6) << 2);
		end
		repeat (4) drive_idle();
		rst_n = 1'b1;
		for (int n = 0; n < N_INSTR; n++) begin
			if (n == N_INSTR / 2) reset_mid_run();
			drive_instr();
			if ($urandom_range(3, 0) == 0) begin
				repeat ($urandom_range(2, 1)) drive_idle();
			end
		end
		while (exp_q.size() != 0) begin
			drive_idle();
		end
		repeat (4) drive_idle();	// Any late out_valid shows up here
		$display("Results %0d, value errors %0d, other errors %0d, assertion errors %0d",
			result_count, value_errors, other_errors, branch_unit_inst.chk_inst.fail_count);
		if (value_errors + other_errors + branch_unit_inst.chk_inst.fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Run timed out after %0d ns with %0d results still pending",
			WATCHDOG_NS, exp_q.size());
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- filelist.f
logic/isa_pkg.sv
logic/bp_pkg.sv
logic/pred_ram.sv
logic/branch_predictor.sv
logic/branch_decode.sv
logic/branch_execute.sv
logic/branch_result.sv
logic/branch_unit.sv
sim/branch_unit_chk.sv
sim/branch_unit_tb.sv
